/* source/tetris_pkg.sv */
/*
  Shared constants, types and tables for the falling-block core.
  The board is a flat bit vector indexed by row * GRID_COLS + col.
  Shape offsets are non-negative and are added to SPAWN_COL at row 0.
  Rotation and line clearing are not modelled.
*/
`default_nettype none

package tetris_pkg;

  // ---------------------------------------------------------------------
  // Grid and timing
  // ---------------------------------------------------------------------
  localparam int GRID_COLS      = 10;
  localparam int GRID_ROWS      = 20;
  localparam int BOARD_BITS     = GRID_COLS * GRID_ROWS;
  localparam int CELL_IDX_W     = $clog2(BOARD_BITS);
  localparam int CELL_PX        = 16;   // Square cells
  localparam int ORIGIN_X       = 240;
  localparam int ORIGIN_Y       = 80;
  localparam int GRAVITY_FRAMES = 60;   // One drop per second at 60 Hz
  localparam int SPAWN_COL      = 4;
  localparam int NUM_SHAPES     = 7;

  // USB HID keycodes
  localparam logic [7:0] KEY_A = 8'h04;  // Left
  localparam logic [7:0] KEY_D = 8'h07;  // Right
  localparam logic [7:0] KEY_S = 8'h16;  // Down

  // Wishbone register map
  localparam int WB_ADDR_W = 2;
  localparam int WB_DATA_W = 16;
  localparam logic [WB_ADDR_W-1:0] REG_KEYCODE = 2'd0;
  localparam logic [WB_ADDR_W-1:0] REG_SCORE   = 2'd1;
  localparam logic [WB_ADDR_W-1:0] REG_STATUS  = 2'd2;

  // ---------------------------------------------------------------------
  // Types
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic [3:0] col;
    logic [4:0] row;
  } cell_t;

  typedef struct packed {
    logic [2:0]  shape;
    cell_t [3:0] cells;
  } piece_t;

  typedef struct packed {
    logic left;
    logic right;
    logic down;
  } step_t;

  typedef logic [BOARD_BITS-1:0] board_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  typedef struct packed {
    logic       game_over;
    logic [2:0] shape;
  } status_t;

  typedef cell_t [3:0] shape_cells_t;

  // Colours
  localparam rgb_t COLOR_BG     = '{8'h00, 8'h00, 8'h00};
  localparam rgb_t COLOR_FRAME  = '{8'h00, 8'h00, 8'h60};
  localparam rgb_t COLOR_LOCKED = '{8'h80, 8'h80, 8'h80};

  // Order I, O, T, S, Z, J, L
  localparam rgb_t SHAPE_COLOR [NUM_SHAPES] = '{
    '{8'h00, 8'hf0, 8'hf0},  // I cyan
    '{8'hf0, 8'hf0, 8'h00},  // O yellow
    '{8'ha0, 8'h00, 8'hf0},  // T purple
    '{8'h00, 8'hf0, 8'h00},  // S green
    '{8'hf0, 8'h00, 8'h00},  // Z red
    '{8'h00, 8'h00, 8'hf0},  // J blue
    '{8'hf0, 8'ha0, 8'h00}   // L orange
  };

  // {col, row} offsets, cell 3 first
  localparam shape_cells_t SHAPE_CELLS [NUM_SHAPES] = '{
    {4'd3, 5'd0, 4'd2, 5'd0, 4'd1, 5'd0, 4'd0, 5'd0},  // I
    {4'd1, 5'd1, 4'd0, 5'd1, 4'd1, 5'd0, 4'd0, 5'd0},  // O
    {4'd1, 5'd1, 4'd2, 5'd0, 4'd1, 5'd0, 4'd0, 5'd0},  // T
    {4'd1, 5'd1, 4'd0, 5'd1, 4'd2, 5'd0, 4'd1, 5'd0},  // S
    {4'd2, 5'd1, 4'd1, 5'd1, 4'd1, 5'd0, 4'd0, 5'd0},  // Z
    {4'd2, 5'd1, 4'd1, 5'd1, 4'd0, 5'd1, 4'd0, 5'd0},  // J
    {4'd2, 5'd1, 4'd1, 5'd1, 4'd0, 5'd1, 4'd2, 5'd0}   // L
  };

  // Flat board bit of a grid cell
  function automatic logic [CELL_IDX_W-1:0] cell_index(cell_t c);
    return CELL_IDX_W'(c.row) * CELL_IDX_W'(GRID_COLS) + CELL_IDX_W'(c.col);
  endfunction

endpackage

`default_nettype wire

/* source/key_step_fsm.sv */
/*
  Turns a held keycode into one step per key press.
  The code is sampled on frame_tick only; a step fires one cycle later
  when the code differs from the previous frame and is A, S or D.
  Holding a key gives one move; release (or another code) re-arms it.
*/
`timescale 1ns/1ps
`default_nettype none

module key_step_fsm (
  input  wire logic            Clk,
  input  wire logic            rst_n,
  input  wire logic            frame_tick,
  input  wire logic [7:0]      keycode,
  output tetris_pkg::step_t    step,
  output logic                 step_valid
);

  logic [7:0]        prev_code;  // Code seen on the last frame
  tetris_pkg::step_t decoded;
  logic              is_move;

  always_comb begin
    decoded       = '0;
    decoded.left  = (keycode == tetris_pkg::KEY_A);
    decoded.right = (keycode == tetris_pkg::KEY_D);
    decoded.down  = (keycode == tetris_pkg::KEY_S);
    is_move       = |decoded;
  end

  // Previous code is the FSM state
  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      prev_code  <= '0;
      step_valid <= 1'b0;
    end else begin
      step_valid <= 1'b0;
      if (frame_tick) begin
        prev_code  <= keycode;
        step_valid <= is_move && (keycode != prev_code);  // New press only
      end
    end
  end

  always_ff @(posedge Clk) begin
    if (frame_tick) step <= decoded;  // Held with step_valid
  end

endmodule

`default_nettype wire

/* source/piece_generator.sv */
/*
  Fixed seven-shape cycle I, O, T, S, Z, J, L.
  next_piece is decoded from the shape counter and stays stable
  until the counter advances on spawn_req. Reset starts at shape I.
*/
`timescale 1ns/1ps
`default_nettype none

module piece_generator (
  input  wire logic           Clk,
  input  wire logic           rst_n,
  input  wire logic           spawn_req,
  output tetris_pkg::piece_t  next_piece
);

  logic [2:0]               shape_cnt;
  tetris_pkg::shape_cells_t offs;

  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      shape_cnt <= '0;
    end else if (spawn_req) begin
      if (shape_cnt == 3'(tetris_pkg::NUM_SHAPES - 1))
        shape_cnt <= '0;                  // Wrap L back to I
      else
        shape_cnt <= shape_cnt + 3'd1;
    end
  end

  // Spawn cells: template offsets shifted to the spawn column
  always_comb begin
    offs             = tetris_pkg::SHAPE_CELLS[shape_cnt];
    next_piece.shape = shape_cnt;
    for (int i = 0; i < 4; i++) begin
      next_piece.cells[i].col = offs[i].col + 4'(tetris_pkg::SPAWN_COL);
      next_piece.cells[i].row = offs[i].row;  // Top row
    end
  end

endmodule

`default_nettype wire

/* source/falling_piece.sv */
/*
  Active piece control. One move candidate per cycle: a key left or
  right wins, otherwise a down move from a key or gravity.
  A blocked down move locks the piece; lock_valid and spawn_req pulse
  in the cycle after it and the next piece is loaded two cycles later.
  A spawn that overlaps the board sets a sticky game_over.
*/
`timescale 1ns/1ps
`default_nettype none

module falling_piece (
  input  wire logic                Clk,
  input  wire logic                rst_n,
  input  wire logic                frame_tick,
  input  wire tetris_pkg::step_t   step,
  input  wire logic                step_valid,
  input  wire tetris_pkg::board_t  board,
  input  wire tetris_pkg::piece_t  next_piece,
  output tetris_pkg::piece_t       active,
  output logic                     lock_valid,
  output logic                     spawn_req,
  output logic                     score_inc,
  output tetris_pkg::status_t      status
);

  typedef enum logic [1:0] {ST_PLAY, ST_LOCK, ST_LOAD, ST_OVER} state_t;

  state_t             state;
  logic [5:0]         grav_cnt;
  logic               grav_due;
  logic               mv_left, mv_right, mv_down;
  logic               blocked;
  logic               game_over;
  tetris_pkg::piece_t cand;

  // Off the grid or on a locked cell
  function automatic logic hits(tetris_pkg::piece_t p, tetris_pkg::board_t b);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (p.cells[i].col >= 4'(tetris_pkg::GRID_COLS) ||
          p.cells[i].row >= 5'(tetris_pkg::GRID_ROWS))
        hit = 1'b1;
      else if (b[tetris_pkg::cell_index(p.cells[i])])
        hit = 1'b1;
    end
    return hit;
  endfunction

  // ---------------------------------------------------------------------
  // Move candidate
  // ---------------------------------------------------------------------
  assign grav_due = frame_tick && (grav_cnt >= 6'(tetris_pkg::GRAVITY_FRAMES - 1));

  always_comb begin
    mv_left  = step_valid && step.left;
    mv_right = step_valid && step.right && !mv_left;
    mv_down  = ((step_valid && step.down) || grav_due) && !mv_left && !mv_right;
    cand     = active;
    for (int i = 0; i < 4; i++) begin
      if (mv_left)  cand.cells[i].col = active.cells[i].col - 4'd1;  // 0 wraps off grid
      if (mv_right) cand.cells[i].col = active.cells[i].col + 4'd1;
      if (mv_down)  cand.cells[i].row = active.cells[i].row + 5'd1;
    end
    blocked = hits(cand, board);
  end

  // ---------------------------------------------------------------------
  // Piece state
  // ---------------------------------------------------------------------
  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      state     <= ST_PLAY;
      grav_cnt  <= '0;
      score_inc <= 1'b0;
      game_over <= 1'b0;
      active    <= next_piece;  // Shape I at spawn
    end else begin
      score_inc <= 1'b0;
      case (state)
        ST_PLAY: begin
          if (mv_down)         grav_cnt <= '0;  // Any down attempt restarts gravity
          else if (frame_tick) grav_cnt <= grav_cnt + 6'd1;
          if ((mv_left || mv_right || mv_down) && !blocked) begin
            active    <= cand;
            score_inc <= mv_down;
          end else if (mv_down) begin
            state <= ST_LOCK;  // Blocked fall
          end
        end
        ST_LOCK: state <= ST_LOAD;  // Board and generator update here
        ST_LOAD: begin
          active <= next_piece;
          if (hits(next_piece, board)) begin
            game_over <= 1'b1;
            state     <= ST_OVER;
          end else begin
            state <= ST_PLAY;
          end
        end
        default: state <= ST_OVER;  // Sticky until reset
      endcase
    end
  end

  assign lock_valid       = (state == ST_LOCK);
  assign spawn_req        = (state == ST_LOCK);
  assign status.game_over = game_over;
  assign status.shape     = active.shape;

endmodule

`default_nettype wire

/* source/playfield.sv */
/*
  Occupancy of locked cells, one bit per grid cell.
  The four cells of the locked piece are set on lock_valid and show
  on board one cycle later. Reset empties the board; rows never clear.
*/
`timescale 1ns/1ps
`default_nettype none

module playfield (
  input  wire logic                Clk,
  input  wire logic                rst_n,
  input  wire logic                lock_valid,
  input  wire tetris_pkg::piece_t  locked,
  output tetris_pkg::board_t       board
);

  tetris_pkg::board_t lock_mask;  // Bits of the piece being locked

  always_comb begin
    lock_mask = '0;
    for (int i = 0; i < 4; i++)
      lock_mask[tetris_pkg::cell_index(locked.cells[i])] = 1'b1;
  end

  always_ff @(posedge Clk) begin
    if (!rst_n)
      board <= '0;
    else if (lock_valid)
      board <= board | lock_mask;  // Cells only accumulate
  end

endmodule

`default_nettype wire

/* source/frame_pixel_mapper.sv */
/*
  Colour of one raster coordinate, registered.
  The colour appears one cycle after draw_x and draw_y.
  Falling piece over locked cell over background; outside the board
  area the frame colour is given.
*/
`timescale 1ns/1ps
`default_nettype none

module frame_pixel_mapper (
  input  wire logic                Clk,
  input  wire logic                rst_n,
  input  wire logic [9:0]          draw_x,
  input  wire logic [9:0]          draw_y,
  input  wire tetris_pkg::board_t  board,
  input  wire tetris_pkg::piece_t  active,
  output tetris_pkg::rgb_t         pixel
);

  localparam int X_END = tetris_pkg::ORIGIN_X + tetris_pkg::GRID_COLS * tetris_pkg::CELL_PX;
  localparam int Y_END = tetris_pkg::ORIGIN_Y + tetris_pkg::GRID_ROWS * tetris_pkg::CELL_PX;

  logic [9:0]        rel_x, rel_y;
  logic [9:0]        cell_x, cell_y;
  logic              in_board;
  logic              on_piece;
  tetris_pkg::cell_t px_cell;
  tetris_pkg::rgb_t  color;

  always_comb begin
    rel_x    = draw_x - 10'(tetris_pkg::ORIGIN_X);
    rel_y    = draw_y - 10'(tetris_pkg::ORIGIN_Y);
    cell_x   = rel_x / 10'(tetris_pkg::CELL_PX);
    cell_y   = rel_y / 10'(tetris_pkg::CELL_PX);
    in_board = (draw_x >= 10'(tetris_pkg::ORIGIN_X)) && (draw_x < 10'(X_END)) &&
               (draw_y >= 10'(tetris_pkg::ORIGIN_Y)) && (draw_y < 10'(Y_END));
    px_cell.col = cell_x[3:0];
    px_cell.row = cell_y[4:0];
    on_piece    = 1'b0;
    for (int i = 0; i < 4; i++)
      if (active.cells[i] == px_cell) on_piece = 1'b1;

    if (!in_board)
      color = tetris_pkg::COLOR_FRAME;
    else if (on_piece)
      color = tetris_pkg::SHAPE_COLOR[active.shape];
    else if (board[tetris_pkg::cell_index(px_cell)])
      color = tetris_pkg::COLOR_LOCKED;
    else
      color = tetris_pkg::COLOR_BG;
  end

  always_ff @(posedge Clk) begin
    if (!rst_n) pixel <= tetris_pkg::COLOR_BG;
    else        pixel <= color;
  end

endmodule

`default_nettype wire

/* source/wb_game_regs.sv */
/*
  Wishbone classic slave, single access only.
  Ack rises one cycle after cyc and stb and lasts one cycle; write data
  is taken and read data presented on the ack cycle.
  Score and status are read only. Unmapped reads return zero.
*/
`timescale 1ns/1ps
`default_nettype none

module wb_game_regs (
  input  wire logic                                 Clk,
  input  wire logic                                 rst_n,
  input  wire logic                                 wb_cyc,
  input  wire logic                                 wb_stb,
  input  wire logic                                 wb_we,
  input  wire logic [tetris_pkg::WB_ADDR_W-1:0]     wb_adr,
  input  wire logic [tetris_pkg::WB_DATA_W-1:0]     wb_dat_w,
  input  wire logic                                 score_inc,
  input  wire tetris_pkg::status_t                  status,
  output logic      [tetris_pkg::WB_DATA_W-1:0]     wb_dat_r,
  output logic                                      wb_ack,
  output logic      [7:0]                           keycode
);

  logic                               req;
  logic [tetris_pkg::WB_DATA_W-1:0]   score;
  logic [tetris_pkg::WB_DATA_W-1:0]   rd_data;

  assign req = wb_cyc && wb_stb && !wb_ack;  // Ack every other cycle at most

  // Read mux, zero extended
  always_comb begin
    rd_data = '0;
    case (wb_adr)
      tetris_pkg::REG_KEYCODE: rd_data[7:0] = keycode;
      tetris_pkg::REG_SCORE:   rd_data      = score;
      tetris_pkg::REG_STATUS:  rd_data[$bits(tetris_pkg::status_t)-1:0] = status;
      default:                 rd_data      = '0;
    endcase
  end

  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      wb_ack  <= 1'b0;
      keycode <= '0;
      score   <= '0;
    end else begin
      wb_ack <= req;
      if (wb_ack && wb_cyc && wb_stb && wb_we && wb_adr == tetris_pkg::REG_KEYCODE)
        keycode <= wb_dat_w[7:0];
      if (score_inc)
        score <= score + 1'b1;  // Wraps at 16 bits
    end
  end

  always_ff @(posedge Clk) begin
    if (req) wb_dat_r <= rd_data;  // Valid while ack is high
  end

endmodule

`default_nettype wire

/* source/tetris_top.sv */
/*
  Falling-block core top level.
  frame_tick and draw_x/draw_y come from an external display timing
  generator; the host reaches the game through the Wishbone port.
*/
`timescale 1ns/1ps
`default_nettype none

module tetris_top (
  input  wire logic                             Clk,
  input  wire logic                             rst_n,
  input  wire logic                             frame_tick,
  input  wire logic [9:0]                       draw_x,
  input  wire logic [9:0]                       draw_y,
  input  wire logic                             wb_cyc,
  input  wire logic                             wb_stb,
  input  wire logic                             wb_we,
  input  wire logic [tetris_pkg::WB_ADDR_W-1:0] wb_adr,
  input  wire logic [tetris_pkg::WB_DATA_W-1:0] wb_dat_w,
  output logic      [tetris_pkg::WB_DATA_W-1:0] wb_dat_r,
  output logic                                  wb_ack,
  output tetris_pkg::rgb_t                      pixel
);

  logic [7:0]          keycode;
  tetris_pkg::step_t   step;
  logic                step_valid;
  tetris_pkg::piece_t  next_piece, active;
  tetris_pkg::board_t  board;
  logic                lock_valid, spawn_req, score_inc;
  tetris_pkg::status_t status;

  // ---------------------------------------------------------------------
  // Host side
  // ---------------------------------------------------------------------
  wb_game_regs u_regs (
    .Clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .score_inc, .status, .wb_dat_r, .wb_ack, .keycode
  );

  key_step_fsm u_keys (.Clk, .rst_n, .frame_tick, .keycode, .step, .step_valid);

  // Game core
  piece_generator u_gen (.Clk, .rst_n, .spawn_req, .next_piece);

  falling_piece u_piece (
    .Clk, .rst_n, .frame_tick, .step, .step_valid, .board, .next_piece,
    .active, .lock_valid, .spawn_req, .score_inc, .status
  );

  playfield u_field (.Clk, .rst_n, .lock_valid, .locked(active), .board);  // Locks the active piece

  frame_pixel_mapper u_pixels (.Clk, .rst_n, .draw_x, .draw_y, .board, .active, .pixel);

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
/*
  Testbench clock and reset, 100 ns period.
  rst_n is low for the first 4 rising edges and rises on a falling edge.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // Half period
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;  // Released between edges
  end

endmodule

`default_nettype wire

/* tb/tetris_assertions.sv */
/*
  Concurrent checks bound into falling_piece and wb_game_regs.
  Ports that a target module lacks are tied to idle values.
  All checks are off while rst_n is low.
*/
`timescale 1ns/1ps
`default_nettype none

module tetris_assertions (
  input wire logic               Clk,
  input wire logic               rst_n,
  input wire logic               wb_ack,
  input wire logic               lock_valid,
  input wire logic               spawn_req,
  input wire tetris_pkg::piece_t active
);

  int unsigned fail_count = 0;  // Read by the testbench at the end
  logic        cells_in_grid;

  always_comb begin
    cells_in_grid = 1'b1;
    for (int i = 0; i < 4; i++)
      if (active.cells[i].col >= 4'(tetris_pkg::GRID_COLS) ||
          active.cells[i].row >= 5'(tetris_pkg::GRID_ROWS))
        cells_in_grid = 1'b0;  // Off the board
  end

  // ---------------------------------------------------------------------
  // Pulse widths and piece range
  // ---------------------------------------------------------------------
  ack_one_cycle: assert property (@(posedge Clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else begin $error("wb_ack held for two cycles"); fail_count++; end

  lock_one_cycle: assert property (@(posedge Clk) disable iff (!rst_n)
                                   lock_valid |=> !lock_valid)
    else begin $error("lock_valid held for two cycles"); fail_count++; end

  spawn_one_cycle: assert property (@(posedge Clk) disable iff (!rst_n)
                                    spawn_req |=> !spawn_req)
    else begin $error("spawn_req held for two cycles"); fail_count++; end

  piece_on_grid: assert property (@(posedge Clk) disable iff (!rst_n) cells_in_grid)
    else begin $error("active cell outside the grid"); fail_count++; end

endmodule

bind falling_piece tetris_assertions u_piece_chk (
  .Clk, .rst_n, .wb_ack(1'b0), .lock_valid, .spawn_req, .active
);

bind wb_game_regs tetris_assertions u_regs_chk (
  .Clk, .rst_n, .wb_ack, .lock_valid(1'b0), .spawn_req(1'b0), .active('0)
);

`default_nettype wire

/* tb/tetris_tb.sv */
/*
  Directed tests of the falling-block core through its top-level ports.
  Inputs change on the falling clock edge and outputs are read there.
  Expected values follow the game rules: one move per key press,
  gravity every GRAVITY_FRAMES frames, lock on a blocked down move.
  The stacking test assumes pieces fall straight into columns 4 to 7.
*/
`timescale 1ns/1ps
`default_nettype none

module tetris_tb;

  logic                             clk;
  logic                             rst_n;
  logic                             frame_tick;
  logic [9:0]                       draw_x;
  logic [9:0]                       draw_y;
  logic                             wb_cyc;
  logic                             wb_stb;
  logic                             wb_we;
  logic [tetris_pkg::WB_ADDR_W-1:0] wb_adr;
  logic [tetris_pkg::WB_DATA_W-1:0] wb_dat_w;
  logic [tetris_pkg::WB_DATA_W-1:0] wb_dat_r;
  logic                             wb_ack;
  tetris_pkg::rgb_t                 pixel;

  int errors;         // Failed checks, whole run
  int errors_before;  // Count at start of the running test
  int tests_run;
  int tests_failed;
  int assert_fails;

  tb_clock_gen u_clk (.clk, .rst_n);

  tetris_top dut (
    .Clk(clk), .rst_n, .frame_tick, .draw_x, .draw_y,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack, .pixel
  );

  // ---------------------------------------------------------------------
  // Typed compares
  // ---------------------------------------------------------------------
  task automatic check_rgb(input tetris_pkg::rgb_t got, input tetris_pkg::rgb_t exp,
                           input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s pixel %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_status(input tetris_pkg::status_t got,
                              input tetris_pkg::status_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s game_over %b shape %0d, expected %b and %0d", $time, what,
               got.game_over, got.shape, exp.game_over, exp.shape);
      errors++;
    end
  endtask

  task automatic check_word(input logic [15:0] got, input logic [15:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s read %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // ---------------------------------------------------------------------
  // Bus, frame and pixel drivers
  // ---------------------------------------------------------------------
  task automatic wb_access(input logic we, input logic [tetris_pkg::WB_ADDR_W-1:0] adr,
                           input logic [15:0] wdata, output logic [15:0] rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 16);
    if (!wb_ack) begin
      $display("Wishbone ack did not arrive within %0d cycles at address %0d", waited, adr);
      errors++;
    end else begin
      rdata = wb_dat_r;
    end
    @(negedge clk);  // Slave takes write data on the edge that ends ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [tetris_pkg::WB_ADDR_W-1:0] adr,
                          input logic [15:0] data);
    logic [15:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [tetris_pkg::WB_ADDR_W-1:0] adr,
                         output logic [15:0] data);
    wb_access(1'b0, adr, 16'h0000, data);
  endtask

  task automatic send_frame();
    @(negedge clk);
    frame_tick = 1'b1;
    @(negedge clk);
    frame_tick = 1'b0;
    repeat (4) @(negedge clk);  // Step, lock and load all settle
  endtask

  // One press then one release frame
  task automatic press_key(input logic [7:0] code);
    wb_write(tetris_pkg::REG_KEYCODE, {8'h00, code});
    send_frame();
    wb_write(tetris_pkg::REG_KEYCODE, 16'h0000);
    send_frame();
  endtask

  task automatic probe_cell(input int col, input int row, output tetris_pkg::rgb_t px);
    @(negedge clk);
    draw_x = 10'(tetris_pkg::ORIGIN_X + col * tetris_pkg::CELL_PX + tetris_pkg::CELL_PX / 2);
    draw_y = 10'(tetris_pkg::ORIGIN_Y + row * tetris_pkg::CELL_PX + tetris_pkg::CELL_PX / 2);
    @(negedge clk);  // Registered colour
    px = pixel;
  endtask

  task automatic scan_cells(input int row, input int first, input int count,
                            input tetris_pkg::rgb_t exp, input string what);
    tetris_pkg::rgb_t px;
    for (int c = first; c < first + count; c++) begin
      probe_cell(c, row, px);
      check_rgb(px, exp, what);
    end
  endtask

  // Frames between two gravity drops, seen as score changes
  task automatic measure_gravity_period(output int period);
    logic [15:0] rd;
    logic [15:0] last;
    int          frames;
    int          drops;
    period = 0;
    frames = 0;
    drops  = 0;
    wb_read(tetris_pkg::REG_SCORE, last);
    while (drops < 2 && frames < 3 * tetris_pkg::GRAVITY_FRAMES) begin
      send_frame();
      frames++;
      period++;
      wb_read(tetris_pkg::REG_SCORE, rd);
      if (rd != last) begin
        if (drops == 0) period = 0;  // Count from the first drop
        drops++;
        last = rd;
      end
    end
    if (drops < 2) period = 0;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d checks wrong", tests_run, name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  // ---------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------
  task automatic register_map();
    logic [15:0] rd;
    logic [7:0]  code;
    wb_read(tetris_pkg::REG_SCORE, rd);
    check_word(rd, 16'd0, "score after reset");
    wb_read(tetris_pkg::REG_STATUS, rd);
    check_status(tetris_pkg::status_t'(rd[3:0]), '{1'b0, 3'd0}, "status after reset");
    code = 8'($urandom);
    wb_write(tetris_pkg::REG_KEYCODE, {8'h00, code});
    wb_read(tetris_pkg::REG_KEYCODE, rd);
    check_word(rd, {8'h00, code}, "keycode readback");
    wb_write(tetris_pkg::REG_SCORE, 16'hffff);  // Read only
    wb_read(tetris_pkg::REG_SCORE, rd);
    check_word(rd, 16'd0, "score after write");
    wb_read(2'd3, rd);
    check_word(rd, 16'd0, "unmapped address");
    wb_write(tetris_pkg::REG_KEYCODE, 16'h0000);  // Idle before frames start
    report_test("register map and reset values");
  endtask

  task automatic one_move_per_press();
    wb_write(tetris_pkg::REG_KEYCODE, {8'h00, tetris_pkg::KEY_D});
    repeat (3) send_frame();  // Held key
    scan_cells(0, 5, 4, tetris_pkg::SHAPE_COLOR[0], "I after held D");
    scan_cells(0, 4, 1, tetris_pkg::COLOR_BG, "cell left by I");
    wb_write(tetris_pkg::REG_KEYCODE, 16'h0000);
    send_frame();  // Release frame
    press_key(tetris_pkg::KEY_D);  // Second press
    scan_cells(0, 6, 4, tetris_pkg::SHAPE_COLOR[0], "I after second D");
    scan_cells(0, 5, 1, tetris_pkg::COLOR_BG, "cell left by I");
    report_test("one move per key press");
  endtask

  task automatic wall_limit();
    repeat (6) press_key(tetris_pkg::KEY_A);  // Column 6 to 0
    scan_cells(0, 0, 4, tetris_pkg::SHAPE_COLOR[0], "I at left wall");
    scan_cells(0, 4, 1, tetris_pkg::COLOR_BG, "right of I");
    repeat (2) press_key(tetris_pkg::KEY_A);
    scan_cells(0, 0, 4, tetris_pkg::SHAPE_COLOR[0], "I pushed into wall");
    scan_cells(0, 4, 1, tetris_pkg::COLOR_BG, "right of I");
    report_test("wall limit");
  endtask

  task automatic score_per_down_move();
    logic [15:0] rd;
    for (int i = 1; i < tetris_pkg::GRID_ROWS; i++) begin
      press_key(tetris_pkg::KEY_S);
      wb_read(tetris_pkg::REG_SCORE, rd);
      check_word(rd, 16'(i), "score after down press");
    end
    scan_cells(tetris_pkg::GRID_ROWS - 1, 0, 4, tetris_pkg::SHAPE_COLOR[0], "I on floor");
    scan_cells(0, 0, 1, tetris_pkg::COLOR_BG, "spawn row after fall");
    report_test("score and down moves");
  endtask

  task automatic lock_and_next_shape();
    logic [15:0] rd;
    press_key(tetris_pkg::KEY_S);  // Blocked by the floor
    scan_cells(tetris_pkg::GRID_ROWS - 1, 0, 4, tetris_pkg::COLOR_LOCKED, "locked I");
    wb_read(tetris_pkg::REG_STATUS, rd);
    check_status(tetris_pkg::status_t'(rd[3:0]), '{1'b0, 3'd1}, "status after lock");
    wb_read(tetris_pkg::REG_SCORE, rd);
    check_word(rd, 16'(tetris_pkg::GRID_ROWS - 1), "score after lock");
    scan_cells(0, 4, 2, tetris_pkg::SHAPE_COLOR[1], "O top row");
    scan_cells(1, 4, 2, tetris_pkg::SHAPE_COLOR[1], "O bottom row");
    report_test("lock, next shape and locked colour");
  endtask

  task automatic gravity_until_game_over();
    logic [15:0]         rd;
    logic [15:0]         score_exp;
    tetris_pkg::status_t st;
    int                  frames;
    int                  period;
    // Rows fallen by O T S Z J L I O T S; the Z after them hits at spawn
    score_exp = 16'(tetris_pkg::GRID_ROWS - 1 + 18 + 16 + 14 + 12 + 10 + 8 + 7 + 5 + 3 + 1);
    frames    = 0;
    st        = '0;
    measure_gravity_period(period);
    check_word(16'(period), 16'(tetris_pkg::GRAVITY_FRAMES), "frames between drops");
    while (!st.game_over && frames < 20000) begin
      send_frame();
      frames++;
      if (frames % tetris_pkg::GRAVITY_FRAMES == 0) begin
        wb_read(tetris_pkg::REG_STATUS, rd);
        st = tetris_pkg::status_t'(rd[3:0]);
      end
    end
    if (!st.game_over) begin
      $display("game over did not occur within %0d frames", frames);
      errors++;
    end else begin
      check_status(st, '{1'b1, 3'd4}, "status at game over");
      wb_read(tetris_pkg::REG_SCORE, rd);
      check_word(rd, score_exp, "score at game over");
      repeat (2 * tetris_pkg::GRAVITY_FRAMES) send_frame();
      wb_read(tetris_pkg::REG_SCORE, rd);
      check_word(rd, score_exp, "score after game over");
      wb_read(tetris_pkg::REG_STATUS, rd);
      check_status(tetris_pkg::status_t'(rd[3:0]), '{1'b1, 3'd4}, "status after game over");
    end
    report_test("gravity and game over");
  endtask

  // ---------------------------------------------------------------------
  // Run
  // ---------------------------------------------------------------------
  initial begin
    frame_tick    = 1'b0;
    draw_x        = '0;
    draw_y        = '0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    errors        = 0;
    errors_before = 0;
    tests_run     = 0;
    tests_failed  = 0;
    void'($urandom(32'hb7df7c35));
    repeat (6) @(negedge clk);  // Past the 4 reset cycles

    register_map();
    one_move_per_press();
    wall_limit();
    score_per_down_move();
    lock_and_next_shape();
    gravity_until_game_over();

    assert_fails = dut.u_piece.u_piece_chk.fail_count + dut.u_regs.u_regs_chk.fail_count;
    $display("tests %0d, failed %0d, wrong checks %0d, assertion failures %0d",
             tests_run, tests_failed, errors, assert_fails);
    if (errors == 0 && tests_failed == 0 && assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
source/tetris_pkg.sv
source/key_step_fsm.sv
source/piece_generator.sv
source/falling_piece.sv
source/playfield.sv
source/frame_pixel_mapper.sv
source/wb_game_regs.sv
source/tetris_top.sv
tb/tb_clock_gen.sv
tb/tetris_assertions.sv
tb/tetris_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the falling-block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tetris_tb -f verilog.f -o tetris_sim

# Keep running after an assertion error so the testbench can report it
out=$(./obj_dir/tetris_sim +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -q "^Verification passed$"; then
  exit 0
else
  exit 1
fi
